/* design/nes_io_pkg.sv */
// ======================================================================
// nes_io_pkg
// Shared types, host register map, button positions and scheduler
// phases for the console glue logic around the NES core.
// ======================================================================
package nes_io_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  nes_btn_t;    // 1 = pressed
  typedef logic [21:0] mem_addr_t;   // 4 MB space

  // NES button bit positions (R L D U START SELECT B A)
  localparam int BTN_A      = 0;
  localparam int BTN_B      = 1;
  localparam int BTN_SELECT = 2;
  localparam int BTN_START  = 3;
  localparam int BTN_UP     = 4;
  localparam int BTN_DOWN   = 5;
  localparam int BTN_LEFT   = 6;
  localparam int BTN_RIGHT  = 7;

  // host register addresses, as sent by the UART demux
  typedef enum logic [7:0] {
    REG_LOADER_CONF = 8'h35,
    REG_LOADER_DATA = 8'h37,
    REG_BTN_P1      = 8'h40,
    REG_BTN_P2      = 8'h41
  } host_reg_e;

  // five-cycle memory slot, NES core runs in the last one
  typedef enum logic [2:0] {
    PHASE_MEM  = 3'd0,
    PHASE_ACT  = 3'd1,
    PHASE_RW   = 3'd2,
    PHASE_WAIT = 3'd3,
    PHASE_NES  = 3'd4
  } slot_phase_e;

  // autofire half period in clk cycles
  localparam int AUTOFIRE_HALF_DEFAULT = 1_000_000;

endpackage

/* design/host_reg_decoder.sv */
// ======================================================================
// host_reg_decoder
// Decodes byte writes from the host UART demux into loader data
// strobes, the loader reset bit and the two host button registers.
// ======================================================================
`timescale 1ns/1ps

module host_reg_decoder (
  input  logic               clk,
  input  logic               sys_resetn,
  input  logic               host_write,
  input  nes_io_pkg::byte_t  host_addr,
  input  nes_io_pkg::byte_t  host_data,
  output logic               loader_strobe,
  output nes_io_pkg::byte_t  loader_byte,
  output logic               loader_reset,
  output nes_io_pkg::nes_btn_t host_btn_p1,
  output nes_io_pkg::nes_btn_t host_btn_p2
);
  import nes_io_pkg::*;

  logic conf_reset;   // bit 0 of the loader conf byte, the only defined bit

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      loader_strobe <= 1'b0;
      loader_byte   <= '0;
      conf_reset    <= 1'b0;
      host_btn_p1   <= '0;
      host_btn_p2   <= '0;
    end else begin
      loader_strobe <= 1'b0;   // single-cycle strobe
      if (host_write) begin
        case (host_addr)
          REG_LOADER_DATA: begin
            loader_strobe <= 1'b1;
            loader_byte   <= host_data;
          end
          REG_LOADER_CONF: conf_reset  <= host_data[0];
          REG_BTN_P1:      host_btn_p1 <= host_data;
          REG_BTN_P2:      host_btn_p2 <= host_data;
          default: ;       // unmapped, ignored
        endcase
      end
    end
  end

  // loader held in reset with the system, or on host request
  assign loader_reset = ~sys_resetn | conf_reset;

endmodule

/* design/pad_mapper.sv */
// ======================================================================
// pad_mapper
// Maps one player's DualShock bytes, USB pad bits and host button
// register to an NES button byte, with autofire on square/triangle.
// ======================================================================
`timescale 1ns/1ps

module pad_mapper #(
  parameter int AUTOFIRE_HALF = nes_io_pkg::AUTOFIRE_HALF_DEFAULT
) (
  input  logic                 clk,
  input  logic                 sys_resetn,
  input  nes_io_pkg::byte_t    ds_byte0,   // active low
  input  nes_io_pkg::byte_t    ds_byte1,   // active low
  input  nes_io_pkg::nes_btn_t usb_btn,
  input  logic                 usb_x,
  input  logic                 usb_y,
  input  nes_io_pkg::nes_btn_t host_btn,
  output nes_io_pkg::nes_btn_t nes_btn
);
  import nes_io_pkg::*;

  localparam int CNT_W = (AUTOFIRE_HALF > 1) ? $clog2(AUTOFIRE_HALF) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AUTOFIRE_HALF - 1);

  logic [1:0]       af_trig;     // 0 square, 1 triangle
  logic [1:0]       af_level;    // toggle flags
  logic [CNT_W-1:0] af_cnt [2];
  logic [1:0]       af_out;
  nes_btn_t         mapped;

  assign af_trig[0] = ~ds_byte1[7] | usb_y;   // square
  assign af_trig[1] = ~ds_byte1[4] | usb_x;   // triangle

  // one counter and toggle flag per fire button
  for (genvar i = 0; i < 2; i++) begin : g_af
    always_ff @(posedge clk) begin
      if (!sys_resetn || !af_trig[i]) begin
        af_cnt[i]   <= '0;
        af_level[i] <= 1'b1;   // first press fires at once
      end else if (af_cnt[i] == CNT_LAST) begin
        af_cnt[i]   <= '0;
        af_level[i] <= ~af_level[i];
      end else begin
        af_cnt[i] <= af_cnt[i] + 1'b1;
      end
    end

    assign af_out[i] = af_trig[i] & af_level[i];
  end

  always_comb begin
    mapped             = '0;
    mapped[BTN_RIGHT]  = ~ds_byte0[5];
    mapped[BTN_LEFT]   = ~ds_byte0[7];
    mapped[BTN_DOWN]   = ~ds_byte0[6];
    mapped[BTN_UP]     = ~ds_byte0[4];
    mapped[BTN_START]  = ~ds_byte0[3];
    mapped[BTN_SELECT] = ~ds_byte0[0];
    mapped[BTN_B]      = ~ds_byte1[6] | af_out[0];   // X, or square autofire
    mapped[BTN_A]      = ~ds_byte1[5] | af_out[1];   // O, or triangle autofire
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      nes_btn <= '0;
    end else begin
      nes_btn <= mapped | usb_btn | host_btn;
    end
  end

endmodule

/* design/joypad_port.sv */
// ======================================================================
// joypad_port
// NES-side controller register for one player. Parallel load while
// the strobe is high, shift right on each falling joypad clock.
// ======================================================================
`timescale 1ns/1ps

module joypad_port (
  input  logic                 clk,
  input  logic                 sys_resetn,
  input  logic                 joypad_strobe,
  input  logic                 joypad_clock,
  input  nes_io_pkg::nes_btn_t nes_btn,
  output logic                 joypad_data
);

  logic       clock_q;     // previous joypad clock level
  logic [7:0] shift_q;
  logic       clock_fall;

  assign clock_fall = clock_q & ~joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      clock_q <= 1'b0;
      shift_q <= '0;
    end else begin
      clock_q <= joypad_clock;
      if (clock_fall) begin
        shift_q <= {1'b0, shift_q[7:1]};   // zeros after the 8th bit
      end else if (joypad_strobe) begin
        shift_q <= nes_btn;
      end
    end
  end

  assign joypad_data = shift_q[0];   // A comes out first

endmodule

/* design/mem_slot_arbiter.sv */
// ======================================================================
// mem_slot_arbiter
// Five-phase memory slot scheduler. Gates NES requests into the
// memory slot, gives loader writes priority and fills idle slots
// with refreshes.
// ======================================================================
`timescale 1ns/1ps

module mem_slot_arbiter (
  input  logic                  clk,
  input  logic                  sys_resetn,
  input  logic                  loader_done,
  input  logic                  nes_read_cpu,
  input  logic                  nes_read_ppu,
  input  logic                  nes_write,
  input  nes_io_pkg::mem_addr_t nes_addr,
  input  nes_io_pkg::byte_t     nes_wdata,
  input  logic                  loader_mem_write,
  input  nes_io_pkg::mem_addr_t loader_mem_addr,
  input  nes_io_pkg::byte_t     loader_mem_data,
  input  logic                  loader_refresh,
  output logic                  run_nes,
  output logic                  mem_read_a,
  output logic                  mem_read_b,
  output logic                  mem_write,
  output logic                  mem_refresh,
  output nes_io_pkg::mem_addr_t mem_addr,
  output nes_io_pkg::byte_t     mem_wdata
);
  import nes_io_pkg::*;

  // phase   | MEM   | ACT   | RW    | WAIT  | NES   |
  // memory  |  cmd  | activ | rd/wr |       | dout  |
  // NES                                     |  run  |
  slot_phase_e phase;
  slot_phase_e phase_next;
  logic        run_mem;
  logic        nes_req;

  always_comb begin
    case (phase)
      PHASE_MEM:  phase_next = PHASE_ACT;
      PHASE_ACT:  phase_next = PHASE_RW;
      PHASE_RW:   phase_next = PHASE_WAIT;
      PHASE_WAIT: phase_next = PHASE_NES;
      default:    phase_next = PHASE_MEM;   // wrap after the NES cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase <= PHASE_MEM;
    end else begin
      phase <= phase_next;
    end
  end

  // NES is held off until the game is loaded
  assign run_mem = (phase == PHASE_MEM) && loader_done;
  assign run_nes = (phase == PHASE_NES) && loader_done;

  assign nes_req = nes_read_cpu | nes_read_ppu | nes_write;

  assign mem_read_a  = nes_read_cpu & run_mem;
  assign mem_read_b  = nes_read_ppu & run_mem;
  assign mem_write   = (nes_write & run_mem) | loader_mem_write;   // loader in any phase
  assign mem_refresh = (run_mem & ~nes_req & ~loader_mem_write)
                     | (loader_refresh & ~loader_mem_write);

  // loader owns the address and data bus while writing
  assign mem_addr  = loader_mem_write ? loader_mem_addr : nes_addr;
  assign mem_wdata = loader_mem_write ? loader_mem_data : nes_wdata;

endmodule

/* design/nes_io_top.sv */
// ======================================================================
// nes_io_top
// Glue logic around the NES core: host register decode, per-player
// button mapping and joypad ports, and the memory slot arbiter.
// ======================================================================
`timescale 1ns/1ps

module nes_io_top #(
  parameter int AUTOFIRE_HALF = nes_io_pkg::AUTOFIRE_HALF_DEFAULT
) (
  input  logic                  clk,
  input  logic                  sys_resetn,
  // host register writes
  input  logic                  host_write,
  input  nes_io_pkg::byte_t     host_addr,
  input  nes_io_pkg::byte_t     host_data,
  output logic                  loader_strobe,
  output nes_io_pkg::byte_t     loader_byte,
  output logic                  loader_reset,
  // player 1 pad
  input  nes_io_pkg::byte_t     ds_byte0_p1,
  input  nes_io_pkg::byte_t     ds_byte1_p1,
  input  nes_io_pkg::nes_btn_t  usb_btn_p1,
  input  logic                  usb_x_p1,
  input  logic                  usb_y_p1,
  // player 2 pad
  input  nes_io_pkg::byte_t     ds_byte0_p2,
  input  nes_io_pkg::byte_t     ds_byte1_p2,
  input  nes_io_pkg::nes_btn_t  usb_btn_p2,
  input  logic                  usb_x_p2,
  input  logic                  usb_y_p2,
  // NES joypad side
  input  logic                  joypad_strobe,
  input  logic [1:0]            joypad_clock,
  output logic [1:0]            joypad_data,
  // memory
  input  logic                  loader_done,
  input  logic                  nes_read_cpu,
  input  logic                  nes_read_ppu,
  input  logic                  nes_write,
  input  nes_io_pkg::mem_addr_t nes_addr,
  input  nes_io_pkg::byte_t     nes_wdata,
  input  logic                  loader_mem_write,
  input  nes_io_pkg::mem_addr_t loader_mem_addr,
  input  nes_io_pkg::byte_t     loader_mem_data,
  input  logic                  loader_refresh,
  output logic                  run_nes,
  output logic                  mem_read_a,
  output logic                  mem_read_b,
  output logic                  mem_write,
  output logic                  mem_refresh,
  output nes_io_pkg::mem_addr_t mem_addr,
  output nes_io_pkg::byte_t     mem_wdata
);
  import nes_io_pkg::*;

  nes_btn_t host_btn_p1, host_btn_p2;   // from host registers
  nes_btn_t nes_btn_p1, nes_btn_p2;     // mapped, into joypad ports

  host_reg_decoder u_host_reg (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .host_write    (host_write),
    .host_addr     (host_addr),
    .host_data     (host_data),
    .loader_strobe (loader_strobe),
    .loader_byte   (loader_byte),
    .loader_reset  (loader_reset),
    .host_btn_p1   (host_btn_p1),
    .host_btn_p2   (host_btn_p2)
  );

  pad_mapper #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_pad_p1 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_byte0   (ds_byte0_p1),
    .ds_byte1   (ds_byte1_p1),
    .usb_btn    (usb_btn_p1),
    .usb_x      (usb_x_p1),
    .usb_y      (usb_y_p1),
    .host_btn   (host_btn_p1),
    .nes_btn    (nes_btn_p1)
  );

  pad_mapper #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_pad_p2 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_byte0   (ds_byte0_p2),
    .ds_byte1   (ds_byte1_p2),
    .usb_btn    (usb_btn_p2),
    .usb_x      (usb_x_p2),
    .usb_y      (usb_y_p2),
    .host_btn   (host_btn_p2),
    .nes_btn    (nes_btn_p2)
  );

  joypad_port u_joy_p1 (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .joypad_strobe (joypad_strobe),   // shared strobe, $4016 write
    .joypad_clock  (joypad_clock[0]),
    .nes_btn       (nes_btn_p1),
    .joypad_data   (joypad_data[0])
  );

  joypad_port u_joy_p2 (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[1]),
    .nes_btn       (nes_btn_p2),
    .joypad_data   (joypad_data[1])
  );

  mem_slot_arbiter u_mem_arb (
    .clk              (clk),
    .sys_resetn       (sys_resetn),
    .loader_done      (loader_done),
    .nes_read_cpu     (nes_read_cpu),
    .nes_read_ppu     (nes_read_ppu),
    .nes_write        (nes_write),
    .nes_addr         (nes_addr),
    .nes_wdata        (nes_wdata),
    .loader_mem_write (loader_mem_write),
    .loader_mem_addr  (loader_mem_addr),
    .loader_mem_data  (loader_mem_data),
    .loader_refresh   (loader_refresh),
    .run_nes          (run_nes),
    .mem_read_a       (mem_read_a),
    .mem_read_b       (mem_read_b),
    .mem_write        (mem_write),
    .mem_refresh      (mem_refresh),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata)
  );

endmodule

/* verification/tb_nes_io.sv */
// ======================================================================
// tb_nes_io
// Directed testbench for the NES glue logic: host decode, pad mapping,
// joypad serial read, autofire, slot scheduler and loader priority.
// ======================================================================
`timescale 1ns/1ps

module tb_nes_io;
  import nes_io_pkg::*;

  localparam int AF_HALF        = 4;
  localparam int TIMEOUT_CYCLES = 4000;   // all tests take roughly 900 cycles

  logic       clk;
  logic       sys_resetn;
  logic       host_write;
  byte_t      host_addr, host_data, loader_byte;
  logic       loader_strobe, loader_reset;
  byte_t      ds_byte0_p1, ds_byte1_p1, ds_byte0_p2, ds_byte1_p2;
  nes_btn_t   usb_btn_p1, usb_btn_p2;
  logic       usb_x_p1, usb_y_p1, usb_x_p2, usb_y_p2;
  logic       joypad_strobe;
  logic [1:0] joypad_clock, joypad_data;
  logic       loader_done, nes_read_cpu, nes_read_ppu, nes_write;
  logic       loader_mem_write, loader_refresh;
  mem_addr_t  nes_addr, loader_mem_addr, mem_addr;
  byte_t      nes_wdata, loader_mem_data, mem_wdata;
  logic       run_nes, mem_read_a, mem_read_b, mem_write, mem_refresh;

  int     errors = 0;
  int     cycles = 0;
  integer seed;
  byte_t  p1_b0, p1_b1;   // last player 1 pad bytes

  nes_io_top #(.AUTOFIRE_HALF(AF_HALF)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_btn(input string name, input nes_btn_t got, input nes_btn_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // R L D U START SELECT B A from the active-low DualShock bytes
  function automatic nes_btn_t expected_pad(input byte_t b0, input byte_t b1);
    return {~b0[5], ~b0[7], ~b0[6], ~b0[4], ~b0[3], ~b0[0], ~b1[6], ~b1[5]};
  endfunction

  task automatic write_host(input byte_t addr, input byte_t data);
    @(posedge clk);
    host_write <= 1'b1;
    host_addr  <= addr;
    host_data  <= data;
    @(posedge clk);
    host_write <= 1'b0;
  endtask

  task automatic drive_pad(input int p, input byte_t b0, input byte_t b1);
    @(posedge clk);
    if (p == 0) begin
      ds_byte0_p1 <= b0;
      ds_byte1_p1 <= b1;
    end else begin
      ds_byte0_p2 <= b0;
      ds_byte1_p2 <= b1;
    end
    repeat (2) @(posedge clk);   // mapper output register
  endtask

  task automatic pulse_strobe;
    @(posedge clk);
    joypad_strobe <= 1'b1;
    @(posedge clk);
    joypad_strobe <= 1'b0;   // port loads on this edge
  endtask

  // 8 bits LSB first, then one more bit after the last fall
  task automatic shift_bits(input int p, output nes_btn_t val, output logic tail);
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      val[i] = joypad_data[p];
      @(posedge clk);
      joypad_clock[p] <= 1'b1;
      @(posedge clk);
      joypad_clock[p] <= 1'b0;
      @(posedge clk);   // fall seen, register shifts
    end
    @(negedge clk);
    tail = joypad_data[p];
  endtask

  task automatic read_serial(input int p, output nes_btn_t val, output logic tail);
    pulse_strobe();
    shift_bits(p, val, tail);
  endtask

  task automatic test_host_decode;
    byte_t b;
    int    strobes;
    b = 8'($random(seed));
    strobes = 0;
    write_host(REG_LOADER_DATA, b);
    repeat (4) begin
      @(negedge clk);
      if (loader_strobe) begin
        strobes++;
        check_byte("loader_byte", loader_byte, b);
      end
    end
    if (strobes != 1) begin
      errors++;
      $display("loader_strobe pulsed %0d times for a single data write", strobes);
    end
    write_host(REG_LOADER_CONF, 8'h01);
    @(negedge clk);
    check_bit("loader_reset", loader_reset, 1'b1);
    write_host(REG_LOADER_CONF, 8'h00);
    @(negedge clk);
    check_bit("loader_reset", loader_reset, 1'b0);
    write_host(8'h36, 8'hff);   // unmapped
    @(negedge clk);
    check_bit("loader_reset", loader_reset, 1'b0);
    check_bit("loader_strobe", loader_strobe, 1'b0);
    check_byte("loader_byte", loader_byte, b);
  endtask

  task automatic test_map_read;
    byte_t    b0, b1;
    nes_btn_t got;
    logic     tail;
    repeat (4) begin
      for (int p = 0; p < 2; p++) begin
        b0 = 8'($random(seed));
        b1 = 8'($random(seed)) | 8'h90;   // square and triangle released
        drive_pad(p, b0, b1);
        read_serial(p, got, tail);
        check_btn(p == 0 ? "joypad p1 byte" : "joypad p2 byte", got, expected_pad(b0, b1));
        check_bit("joypad tail", tail, 1'b0);
        if (p == 0) begin
          p1_b0 = b0;
          p1_b1 = b1;
        end
      end
    end
  endtask

  task automatic test_or_sources;
    byte_t    b0, b1;
    nes_btn_t usb, hb, got;
    logic     tail;
    b0  = 8'($random(seed));
    b1  = 8'($random(seed)) | 8'h90;
    usb = 8'($random(seed));
    hb  = 8'($random(seed));
    @(posedge clk);
    usb_btn_p2 <= usb;
    drive_pad(1, b0, b1);
    write_host(REG_BTN_P2, hb);
    read_serial(1, got, tail);
    check_btn("joypad p2 byte", got, expected_pad(b0, b1) | usb | hb);
    read_serial(0, got, tail);
    check_btn("joypad p1 byte", got, expected_pad(p1_b0, p1_b1));
  endtask

  // the port loads m cycles after the square trigger rises
  task automatic sample_autofire(input int m);
    nes_btn_t got;
    logic     tail;
    logic     exp_b;
    exp_b = (((m - 2) / AF_HALF) % 2) == 0;
    @(posedge clk);
    ds_byte1_p1 <= 8'hff;
    repeat (2) @(posedge clk);
    ds_byte1_p1 <= 8'h7f;   // square held
    repeat (m - 2) @(posedge clk);
    pulse_strobe();
    shift_bits(0, got, tail);
    check_bit("joypad p1 B", got[BTN_B], exp_b);
    check_bit("joypad p1 A", got[BTN_A], 1'b0);
  endtask

  task automatic test_autofire;
    int       offsets [8] = '{2, 3, 5, 6, 9, 10, 13, 14};
    nes_btn_t got;
    logic     tail;
    @(posedge clk);
    ds_byte0_p1 <= 8'hff;
    foreach (offsets[i]) sample_autofire(offsets[i]);
    @(posedge clk);
    ds_byte1_p1 <= 8'hff;   // release
    repeat (3) @(posedge clk);
    read_serial(0, got, tail);
    check_bit("joypad p1 B", got[BTN_B], 1'b0);
  endtask

  task automatic check_schedule(input logic cpu, input logic ppu, input logic wr);
    mem_addr_t a;
    byte_t     d;
    int        n;
    logic      slot;
    a = 22'($random(seed));
    d = 8'($random(seed));
    n = 0;
    @(posedge clk);
    loader_done  <= 1'b1;
    nes_read_cpu <= cpu;
    nes_read_ppu <= ppu;
    nes_write    <= wr;
    nes_addr     <= a;
    nes_wdata    <= d;
    @(negedge clk);
    while (!run_nes && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!run_nes) begin
      errors++;
      $display("run_nes did not pulse within 10 cycles with loader_done high");
    end
    for (int k = 1; k <= 10; k++) begin
      @(negedge clk);
      slot = (k % 5 == 1);   // memory slot right after the NES cycle
      check_bit("run_nes", run_nes, k % 5 == 0);
      check_bit("mem_read_a", mem_read_a, cpu & slot);
      check_bit("mem_read_b", mem_read_b, ppu & slot);
      check_bit("mem_write", mem_write, wr & slot);
      check_bit("mem_refresh", mem_refresh, slot & ~(cpu | ppu | wr));
      check_addr("mem_addr", mem_addr, a);
      check_byte("mem_wdata", mem_wdata, d);
    end
  endtask

  // idle NES side shows a missing refresh gate, a pending read a missing read gate
  task automatic check_held_off(input logic cpu);
    @(posedge clk);
    loader_done  <= 1'b0;
    nes_read_cpu <= cpu;
    nes_write    <= 1'b0;
    repeat (12) begin
      @(negedge clk);
      check_bit("run_nes", run_nes, 1'b0);
      check_bit("mem_read_a", mem_read_a, 1'b0);
      check_bit("mem_refresh", mem_refresh, 1'b0);
    end
  endtask

  task automatic check_loader_priority;
    mem_addr_t a;
    byte_t     d;
    a = 22'($random(seed));
    d = 8'($random(seed));
    @(posedge clk);
    loader_done      <= 1'b1;
    nes_read_cpu     <= 1'b0;
    nes_write        <= 1'b1;
    loader_mem_write <= 1'b1;
    loader_mem_addr  <= a;
    loader_mem_data  <= d;
    loader_refresh   <= 1'b1;
    repeat (5) begin   // one pass through every phase
      @(negedge clk);
      check_bit("mem_write", mem_write, 1'b1);
      check_addr("mem_addr", mem_addr, a);
      check_byte("mem_wdata", mem_wdata, d);
      check_bit("mem_refresh", mem_refresh, 1'b0);
    end
    @(posedge clk);
    loader_mem_write <= 1'b0;
    nes_write        <= 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_bit("mem_refresh", mem_refresh, 1'b1);
      check_bit("mem_write", mem_write, 1'b0);
    end
  endtask

  initial begin
    seed             = 49;
    sys_resetn       = 1'b0;
    host_write       = 1'b0;
    host_addr        = '0;
    host_data        = '0;
    ds_byte0_p1      = 8'hff;   // nothing pressed on the active-low bytes
    ds_byte1_p1      = 8'hff;
    ds_byte0_p2      = 8'hff;
    ds_byte1_p2      = 8'hff;
    usb_btn_p1       = '0;
    usb_btn_p2       = '0;
    usb_x_p1         = 1'b0;
    usb_y_p1         = 1'b0;
    usb_x_p2         = 1'b0;
    usb_y_p2         = 1'b0;
    joypad_strobe    = 1'b0;
    joypad_clock     = '0;
    loader_done      = 1'b0;
    nes_read_cpu     = 1'b0;
    nes_read_ppu     = 1'b0;
    nes_write        = 1'b0;
    nes_addr         = '0;
    nes_wdata        = '0;
    loader_mem_write = 1'b0;
    loader_mem_addr  = '0;
    loader_mem_data  = '0;
    loader_refresh   = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit("loader_reset", loader_reset, 1'b1);   // follows system reset
    @(posedge clk);
    sys_resetn <= 1'b1;
    test_host_decode();
    test_map_read();
    test_or_sources();
    test_autofire();
    check_schedule(1'b1, 1'b0, 1'b0);
    check_schedule(1'b0, 1'b1, 1'b0);
    check_schedule(1'b0, 1'b0, 1'b1);
    check_schedule(1'b0, 1'b0, 1'b0);
    check_held_off(1'b1);
    check_held_off(1'b0);
    check_loader_priority();
    $display("checks done after %0d cycles, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
design/nes_io_pkg.sv
design/host_reg_decoder.sv
design/pad_mapper.sv
design/joypad_port.sv
design/mem_slot_arbiter.sv
design/nes_io_top.sv
verification/tb_nes_io.sv

/* Makefile */
TOP := tb_nes_io

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module nes_io_top -f filelist.f

clean:
	rm -rf obj_dir sim.log
